//--- rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// --------------------------------------------------
// core sizing
// --------------------------------------------------
`define RV_XLEN 32
`define RV_REG_COUNT 32

// first fetch address out of reset
`define RV_RESET_VECTOR 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- rv_isa_pkg.sv
`include "rv_core_macros.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // --------------------------------------------------
    // instruction formats
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } j_fmt_t;

    // one fetched word, seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

//--- rv_pipe_pkg.sv
package rv_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // operand a source, zero for lui
    typedef enum logic [1:0] {
        A_SEL_RS1,
        A_SEL_PC,
        A_SEL_ZERO
    } a_sel_t;

    typedef enum logic {
        B_SEL_RS2,
        B_SEL_IMM
    } b_sel_t;

    // always is used by jal
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS
    } br_cond_t;

    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              redirect_i,
    input  rv_isa_pkg::word_t redirect_pc_i,
    output rv_isa_pkg::word_t imem_addr_o,
    output rv_isa_pkg::word_t fet_pc_o,
    output logic              fet_valid_o
);
    import rv_isa_pkg::*;

    word_t pc_q;
    word_t pc_next;

    assign imem_addr_o = pc_q;

    // taken branch or jal in exe wins over sequential fetch
    assign pc_next = redirect_i ? redirect_pc_i : pc_q + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= `RV_RESET_VECTOR;
            fet_valid_o <= 1'b0;
        end else begin
            pc_q        <= pc_next;
            // word returned after a redirect is wrong path
            fet_valid_o <= !redirect_i;
        end
    end

    // follows the memory latency so decode sees pc with its word
    always_ff @(posedge clk) begin
        fet_pc_o <= pc_q;
    end

endmodule

//--- rv_reg_file.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_reg_file (
    input  logic                  clk,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t waddr_i,
    input  rv_isa_pkg::word_t     wdata_i,
    input  rv_isa_pkg::reg_addr_t raddr_a_i,
    input  rv_isa_pkg::reg_addr_t raddr_b_i,
    output rv_isa_pkg::word_t     rdata_a_o,
    output rv_isa_pkg::word_t     rdata_b_o
);
    import rv_isa_pkg::*;

    word_t regs [`RV_REG_COUNT];

    // x0 stays zero, same-cycle write goes straight through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (addr == waddr_i)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

//--- rv_decode.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_isa_pkg::word_t      imem_data_i,
    input  rv_isa_pkg::word_t      fet_pc_i,
    input  logic                   fet_valid_i,
    input  logic                   redirect_i,
    input  logic                   wb_we_i,
    input  rv_isa_pkg::reg_addr_t  wb_rd_i,
    input  rv_isa_pkg::word_t      wb_data_i,
    output logic                   dx_valid_o,
    output rv_isa_pkg::word_t      dx_pc_o,
    output rv_isa_pkg::reg_addr_t  dx_rs1_o,
    output rv_isa_pkg::reg_addr_t  dx_rs2_o,
    output rv_isa_pkg::word_t      dx_rs1_data_o,
    output rv_isa_pkg::word_t      dx_rs2_data_o,
    output rv_isa_pkg::word_t      dx_imm_o,
    output rv_isa_pkg::reg_addr_t  dx_rd_o,
    output logic                   dx_rd_we_o,
    output rv_pipe_pkg::alu_op_t   dx_alu_op_o,
    output rv_pipe_pkg::a_sel_t    dx_a_sel_o,
    output rv_pipe_pkg::b_sel_t    dx_b_sel_o,
    output rv_pipe_pkg::br_cond_t  dx_br_cond_o,
    output rv_pipe_pkg::wb_sel_t   dx_wb_sel_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    inst_u    inst;
    logic     is_alt;
    logic     load;
    logic     rd_we;
    alu_op_t  alu_op;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    br_cond_t br_cond;
    wb_sel_t  wb_sel;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;

    // shared by register and immediate forms, sub only for register form
    function automatic alu_op_t alu_decode(logic [2:0] funct3, logic alt, logic reg_form);
        case (funct3)
            F3_ADD_SUB: return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    // invalid fetch slots decode as a nop
    assign inst   = fet_valid_i ? imem_data_i : `RV_NOP;
    assign is_alt = (inst.r.funct7 == F7_ALT);
    assign load   = fet_valid_i && !redirect_i;

    // --------------------------------------------------
    // control decode
    // --------------------------------------------------
    always_comb begin
        alu_op  = ALU_ADD;
        a_sel   = A_SEL_RS1;
        b_sel   = B_SEL_IMM;
        br_cond = BR_NONE;
        wb_sel  = WB_ALU;
        rd_we   = 1'b0;
        case (inst.r.opcode)
            OP: begin
                alu_op = alu_decode(inst.r.funct3, is_alt, 1'b1);
                b_sel  = B_SEL_RS2;
                rd_we  = 1'b1;
            end
            OP_IMM: begin
                alu_op = alu_decode(inst.i.funct3, is_alt, 1'b0);
                rd_we  = 1'b1;
            end
            LUI: begin
                a_sel = A_SEL_ZERO;
                rd_we = 1'b1;
            end
            BRANCH: begin
                // alu builds the target, compare runs beside it
                a_sel = A_SEL_PC;
                case (inst.b.funct3)
                    F3_BEQ:  br_cond = BR_EQ;
                    F3_BNE:  br_cond = BR_NE;
                    F3_BLT:  br_cond = BR_LT;
                    F3_BGE:  br_cond = BR_GE;
                    F3_BLTU: br_cond = BR_LTU;
                    F3_BGEU: br_cond = BR_GEU;
                    default: br_cond = BR_NONE;
                endcase
            end
            JAL: begin
                a_sel   = A_SEL_PC;
                br_cond = BR_ALWAYS;
                wb_sel  = WB_PC4;
                rd_we   = 1'b1;
            end
            default: ;
        endcase
    end

    // immediate per format
    always_comb begin
        case (inst.r.opcode)
            OP_IMM:  imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            LUI:     imm = {inst.u.imm31_12, 12'b0};
            BRANCH:  imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                            inst.b.imm4_1, 1'b0};
            JAL:     imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                            inst.j.imm10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    rv_reg_file rv_reg_file_inst (
        .clk       (clk),
        .we_i      (wb_we_i),
        .waddr_i   (wb_rd_i),
        .wdata_i   (wb_data_i),
        .raddr_a_i (inst.i.rs1),
        .raddr_b_i (inst.r.rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    // --------------------------------------------------
    // dec/exe register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dx_valid_o   <= 1'b0;
            dx_rd_we_o   <= 1'b0;
            dx_br_cond_o <= BR_NONE;
        end else begin
            dx_valid_o   <= load;
            dx_rd_we_o   <= load && rd_we;
            // a squashed branch must not redirect from exe
            dx_br_cond_o <= load ? br_cond : BR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        dx_pc_o       <= fet_pc_i;
        dx_rs1_o      <= inst.i.rs1;
        dx_rs2_o      <= inst.r.rs2;
        dx_rs1_data_o <= rs1_data;
        dx_rs2_data_o <= rs2_data;
        dx_imm_o      <= imm;
        dx_rd_o       <= inst.r.rd;
        dx_alu_op_o   <= alu_op;
        dx_a_sel_o    <= a_sel;
        dx_b_sel_o    <= b_sel;
        dx_wb_sel_o   <= wb_sel;
    end

endmodule

//--- rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dx_valid_i,
    input  rv_isa_pkg::word_t      dx_pc_i,
    input  rv_isa_pkg::reg_addr_t  dx_rs1_i,
    input  rv_isa_pkg::reg_addr_t  dx_rs2_i,
    input  rv_isa_pkg::word_t      dx_rs1_data_i,
    input  rv_isa_pkg::word_t      dx_rs2_data_i,
    input  rv_isa_pkg::word_t      dx_imm_i,
    input  rv_isa_pkg::reg_addr_t  dx_rd_i,
    input  logic                   dx_rd_we_i,
    input  rv_pipe_pkg::alu_op_t   dx_alu_op_i,
    input  rv_pipe_pkg::a_sel_t    dx_a_sel_i,
    input  rv_pipe_pkg::b_sel_t    dx_b_sel_i,
    input  rv_pipe_pkg::br_cond_t  dx_br_cond_i,
    input  rv_pipe_pkg::wb_sel_t   dx_wb_sel_i,
    output logic                   redirect_o,
    output rv_isa_pkg::word_t      redirect_pc_o,
    output logic                   wb_we_o,
    output rv_isa_pkg::reg_addr_t  wb_rd_o,
    output rv_isa_pkg::word_t      wb_data_o,
    output logic                   retire_valid_o,
    output rv_isa_pkg::word_t      retire_pc_o,
    output rv_isa_pkg::reg_addr_t  retire_rd_o,
    output rv_isa_pkg::word_t      retire_data_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic  wb_nz;
    logic  taken;
    word_t rs1_val;
    word_t rs2_val;
    word_t alu_a;
    word_t alu_b;
    word_t alu_res;

    // wbk writes a real register this cycle
    assign wb_nz = wb_we_o && (wb_rd_o != '0);

    // --------------------------------------------------
    // forwarding from wbk
    // --------------------------------------------------
    assign rs1_val = (wb_nz && (wb_rd_o == dx_rs1_i)) ? wb_data_o : dx_rs1_data_i;
    assign rs2_val = (wb_nz && (wb_rd_o == dx_rs2_i)) ? wb_data_o : dx_rs2_data_i;

    always_comb begin
        case (dx_a_sel_i)
            A_SEL_PC:   alu_a = dx_pc_i;
            A_SEL_ZERO: alu_a = '0;
            default:    alu_a = rs1_val;
        endcase
    end

    assign alu_b = (dx_b_sel_i == B_SEL_IMM) ? dx_imm_i : rs2_val;

    always_comb begin
        case (dx_alu_op_i)
            ALU_SUB:  alu_res = alu_a - alu_b;
            ALU_AND:  alu_res = alu_a & alu_b;
            ALU_OR:   alu_res = alu_a | alu_b;
            ALU_XOR:  alu_res = alu_a ^ alu_b;
            ALU_SLT:  alu_res = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: alu_res = word_t'(alu_a < alu_b);
            ALU_SLL:  alu_res = alu_a << alu_b[4:0];
            ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(alu_a) >>> alu_b[4:0]);
            default:  alu_res = alu_a + alu_b;
        endcase
    end

    // branch compare on the forwarded sources
    always_comb begin
        case (dx_br_cond_i)
            BR_EQ:     taken = (rs1_val == rs2_val);
            BR_NE:     taken = (rs1_val != rs2_val);
            BR_LT:     taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:    taken = (rs1_val < rs2_val);
            BR_GEU:    taken = (rs1_val >= rs2_val);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // target is pc + imm out of the alu
    assign redirect_o    = dx_valid_i && taken;
    assign redirect_pc_o = alu_res;

    // --------------------------------------------------
    // exe/wbk register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o <= 1'b0;
            wb_we_o        <= 1'b0;
        end else begin
            retire_valid_o <= dx_valid_i;
            wb_we_o        <= dx_valid_i && dx_rd_we_i;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_o <= dx_pc_i;
        wb_rd_o     <= dx_rd_i;
        wb_data_o   <= (dx_wb_sel_i == WB_PC4) ? dx_pc_i + word_t'(4) : alu_res;
    end

    // nothing written shows up as x0 with zero data
    assign retire_rd_o   = wb_nz ? wb_rd_o : '0;
    assign retire_data_o = wb_nz ? wb_data_o : '0;

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                  clk,
    input  logic                  rst,
    output rv_isa_pkg::word_t     imem_addr_o,
    input  rv_isa_pkg::word_t     imem_data_i,
    output logic                  retire_valid_o,
    output rv_isa_pkg::word_t     retire_pc_o,
    output rv_isa_pkg::reg_addr_t retire_rd_o,
    output rv_isa_pkg::word_t     retire_data_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // fet to dec
    word_t     fet_pc;
    logic      fet_valid;

    // exe back to fet and dec
    logic      redirect;
    word_t     redirect_pc;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // dec/exe register
    logic      dx_valid;
    word_t     dx_pc;
    reg_addr_t dx_rs1;
    reg_addr_t dx_rs2;
    word_t     dx_rs1_data;
    word_t     dx_rs2_data;
    word_t     dx_imm;
    reg_addr_t dx_rd;
    logic      dx_rd_we;
    alu_op_t   dx_alu_op;
    a_sel_t    dx_a_sel;
    b_sel_t    dx_b_sel;
    br_cond_t  dx_br_cond;
    wb_sel_t   dx_wb_sel;

    rv_fetch rv_fetch_inst (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .fet_pc_o      (fet_pc),
        .fet_valid_o   (fet_valid)
    );

    rv_decode rv_decode_inst (
        .clk           (clk),
        .rst           (rst),
        .imem_data_i   (imem_data_i),
        .fet_pc_i      (fet_pc),
        .fet_valid_i   (fet_valid),
        .redirect_i    (redirect),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .dx_valid_o    (dx_valid),
        .dx_pc_o       (dx_pc),
        .dx_rs1_o      (dx_rs1),
        .dx_rs2_o      (dx_rs2),
        .dx_rs1_data_o (dx_rs1_data),
        .dx_rs2_data_o (dx_rs2_data),
        .dx_imm_o      (dx_imm),
        .dx_rd_o       (dx_rd),
        .dx_rd_we_o    (dx_rd_we),
        .dx_alu_op_o   (dx_alu_op),
        .dx_a_sel_o    (dx_a_sel),
        .dx_b_sel_o    (dx_b_sel),
        .dx_br_cond_o  (dx_br_cond),
        .dx_wb_sel_o   (dx_wb_sel)
    );

    rv_execute rv_execute_inst (
        .clk            (clk),
        .rst            (rst),
        .dx_valid_i     (dx_valid),
        .dx_pc_i        (dx_pc),
        .dx_rs1_i       (dx_rs1),
        .dx_rs2_i       (dx_rs2),
        .dx_rs1_data_i  (dx_rs1_data),
        .dx_rs2_data_i  (dx_rs2_data),
        .dx_imm_i       (dx_imm),
        .dx_rd_i        (dx_rd),
        .dx_rd_we_i     (dx_rd_we),
        .dx_alu_op_i    (dx_alu_op),
        .dx_a_sel_i     (dx_a_sel),
        .dx_b_sel_i     (dx_b_sel),
        .dx_br_cond_i   (dx_br_cond),
        .dx_wb_sel_i    (dx_wb_sel),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .wb_we_o        (wb_we),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

//--- rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker (
    input logic              clk,
    input logic              rst,
    input rv_isa_pkg::word_t imem_addr_i,
    input logic              retire_valid_i,
    input rv_isa_pkg::word_t retire_pc_i
);

    // bumped by every failing assertion, watched by the testbench
    int unsigned fail_count = 0;

    // --------------------------------------------------
    // top-level port properties
    // --------------------------------------------------
    retire_low_after_reset: assert property (@(posedge clk) rst |=> !retire_valid_i)
        else begin
            fail_count++;
            $error("retire_valid_o was high in the cycle after reset");
        end

    fetch_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr_o is not word aligned: %h", imem_addr_i);
        end

    retire_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        retire_valid_i |-> retire_pc_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("retire_pc_o is not word aligned: %h", retire_pc_i);
        end

endmodule

bind rv_core rv_core_checker rv_core_checker_inst (
    .clk            (clk),
    .rst            (rst),
    .imem_addr_i    (imem_addr_o),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o)
);

//--- rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_core_tb;
    import rv_isa_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int LAST = PROG_LEN - 1;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 100;
    localparam word_t LOOP_PC = word_t'(LAST * 4);

    // instruction kinds of the random program
    localparam int K_REG = 0;
    localparam int K_IMM = 1;
    localparam int K_LUI = 2;
    localparam int K_BR  = 3;
    localparam int K_JAL = 4;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    word_t     imem_data;
    logic      retire_valid;
    word_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_data;
    logic      loop_reached;

    // fields kept per slot so the model needs no decoder
    word_t      prog [PROG_LEN];
    int         kind [PROG_LEN];
    logic [2:0] f3 [PROG_LEN];
    logic       alt [PROG_LEN];
    reg_addr_t  rd [PROG_LEN];
    reg_addr_t  rs1 [PROG_LEN];
    reg_addr_t  rs2 [PROG_LEN];
    word_t      imm [PROG_LEN];
    retire_t    exp_q [$];

    rv_core rv_core_inst (
        .clk            (clk),
        .rst            (rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    function automatic word_t encode(int i);
        case (kind[i])
            K_REG:   return {alt[i] ? F7_ALT : 7'b0, rs2[i], rs1[i], f3[i], rd[i], OP};
            K_IMM:   return {imm[i][11:0], rs1[i], f3[i], rd[i], OP_IMM};
            K_LUI:   return {imm[i][31:12], rd[i], LUI};
            K_BR:    return {imm[i][12], imm[i][10:5], rs2[i], rs1[i], f3[i], imm[i][4:1],
                             imm[i][11], BRANCH};
            default: return {imm[i][20], imm[i][10:1], imm[i][11], imm[i][19:12], rd[i], JAL};
        endcase
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic word_t alu_ref(logic [2:0] op, logic sub_sra, word_t a, word_t b);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (op)
            3'd0:    return sub_sra ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return sub_sra ? sra : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] op, word_t a, word_t b);
        case (op)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic build_program();
        word_t r;
        int    hop;
        int    n;
        for (int i = 0; i < PROG_LEN; i++) begin
            r      = $urandom;
            n      = $urandom % 10;
            rd[i]  = reg_addr_t'($urandom % 6);
            rs1[i] = reg_addr_t'($urandom % 6);
            rs2[i] = reg_addr_t'($urandom % 6);
            f3[i]  = 3'($urandom % 8);
            alt[i] = 1'b0;
            imm[i] = {{20{r[11]}}, r[11:0]};
            if (i < 5) begin
                // x1..x5 get known values before any read
                n     = 6;
                rd[i] = reg_addr_t'(i + 1);
            end else if (i == LAST) begin
                n     = 9;
                rd[i] = '0;
            end
            if (n < 3) begin
                kind[i] = K_REG;
                alt[i]  = (f3[i] == 3'd0 || f3[i] == 3'd5) && r[31];
            end else if (n < 6) begin
                kind[i] = K_IMM;
                if (f3[i] == 3'd1 || f3[i] == 3'd5) begin
                    // shamt form, srai carries the alt funct7
                    alt[i] = (f3[i] == 3'd5) && r[31];
                    imm[i] = {20'b0, alt[i] ? F7_ALT : 7'b0, r[4:0]};
                end
            end else if (n == 6) begin
                kind[i] = K_LUI;
                imm[i]  = {r[31:12], 12'b0};
            end else begin
                kind[i] = (n < 9) ? K_BR : K_JAL;
                if (f3[i] == 3'd2 || f3[i] == 3'd3) begin
                    f3[i] = f3[i] + 3'd4;
                end
                // forward only, the last slot jumps to itself
                hop = 1 + int'($urandom % 8);
                if (i + hop > LAST) begin
                    hop = LAST - i;
                end
                imm[i] = word_t'(hop * 4);
            end
            prog[i] = encode(i);
        end
    endtask

    task automatic run_model();
        word_t   regs [`RV_REG_COUNT];
        word_t   res;
        logic    wr;
        logic    done;
        int      i;
        int      next;
        retire_t ent;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            regs[r] = '0;
        end
        i    = 0;
        done = 1'b0;
        while (!done) begin
            res  = '0;
            wr   = 1'b1;
            next = i + 1;
            case (kind[i])
                K_REG: res = alu_ref(f3[i], alt[i], regs[rs1[i]], regs[rs2[i]]);
                K_IMM: res = alu_ref(f3[i], alt[i], regs[rs1[i]], imm[i]);
                K_LUI: res = imm[i];
                K_BR: begin
                    wr = 1'b0;
                    if (branch_ref(f3[i], regs[rs1[i]], regs[rs2[i]])) begin
                        next = i + int'(imm[i] >> 2);
                    end
                end
                default: begin
                    res  = word_t'(i * 4 + 4);
                    next = i + int'(imm[i] >> 2);
                end
            endcase
            // nothing written retires as x0 with zero data
            wr       = wr && (rd[i] != '0);
            ent.pc   = word_t'(i * 4);
            ent.rd   = wr ? rd[i] : '0;
            ent.data = wr ? res : '0;
            exp_q.push_back(ent);
            if (wr) begin
                regs[rd[i]] = res;
            end
            done = (i == LAST);
            i    = next;
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        if (addr < word_t'(PROG_LEN * 4)) begin
            return prog[addr >> 2];
        end
        return `RV_NOP;
    endfunction

    // --------------------------------------------------
    // clock, memory, monitor, watchdog
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one cycle read latency
    initial begin
        word_t addr;
        imem_data = `RV_NOP;
        forever begin
            @(negedge clk);
            addr = imem_addr;
            @(posedge clk);
            #1;
            imem_data = fetch_word(addr);
        end
    end

    always @(negedge clk) begin
        retire_t ent;
        if (rv_core_inst.rv_core_checker_inst.fail_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end else if (!rst && retire_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("an instruction retired after the model ran out");
            end else begin
                ent = exp_q.pop_front();
                compare_value("retire_pc_o", retire_pc, ent.pc);
                compare_value("retire_rd_o", word_t'(retire_rd), word_t'(ent.rd));
                compare_value("retire_data_o", retire_data, ent.data);
                if (ent.pc == LOOP_PC) begin
                    loop_reached = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES + 2) @(posedge clk);
        stop_with_failure($sformatf("timeout: self-loop at 0x%08h not retired in %0d cycles",
                                    LOOP_PC, TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(74436));
        rst          = 1'b1;
        loop_reached = 1'b0;
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (loop_reached);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- rv_core.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_fetch.sv
rv_reg_file.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
rv_core_checker.sv
rv_core_tb.sv

//--- Makefile
SRCS = rv_core_macros.svh rv_isa_pkg.sv rv_pipe_pkg.sv rv_fetch.sv rv_reg_file.sv \
       rv_decode.sv rv_execute.sv rv_core.sv rv_core_checker.sv rv_core_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vrv_core_tb: $(SRCS) rv_core.f
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f rv_core.f \
		-o Vrv_core_tb

run: obj_dir/Vrv_core_tb
	./obj_dir/Vrv_core_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
